//--- compile.f
src/ram_pkg.sv
src/ram_array.sv
src/mlab_ram.sv
src/m20k_ram.sv
src/low_latency_ram.sv
src/ram_set_top.sv
sim/ram_set_assertions.sv
sim/ram_set_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module ram_set_tb -f compile.f -o ram_set_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/ram_set_sim)
echo "$out"
echo "$out" | grep -q 'All tests passed!' && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- sim/ram_set_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module ram_set_assertions (
    input logic                clk,
    input logic                arst_n,
    input ram_pkg::m20k_read_t m20k_read,
    input ram_pkg::ll_read_t   ll_read,
    input ram_pkg::ram_data_t  mlab_rdata,
    input ram_pkg::ram_data_t  m20k_rdata,
    input ram_pkg::ram_data_t  ll_rdata
);

    int error_count = 0;

    // Outputs are cleared in reset and on the first edge out of it
    property outputs_zero_in_reset;
        @(posedge clk) (!arst_n || $rose(arst_n)) |->
            (mlab_rdata == '0 && m20k_rdata == '0 && ll_rdata == '0);
    endproperty

    property m20k_zero_when_disabled;
        @(posedge clk) disable iff (!arst_n)
            !m20k_read.en |-> ##3 (m20k_rdata == '0);
    endproperty

    // Stalled edges hold the output register
    property ll_holds_when_stalled;
        @(posedge clk) disable iff (!arst_n)
            !ll_read.ce |=> $stable(ll_rdata);
    endproperty

    zero_in_reset_a: assert property (outputs_zero_in_reset) else begin
        $error("outputs not zero during or right after reset");
        error_count++;
    end

    m20k_disabled_a: assert property (m20k_zero_when_disabled) else begin
        $error("m20k_rdata not zero three cycles after a disabled read");
        error_count++;
    end

    ll_stall_a: assert property (ll_holds_when_stalled) else begin
        $error("ll_rdata changed on a cycle with ce low");
        error_count++;
    end

endmodule

bind ram_set_top ram_set_assertions ram_set_assertions_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .m20k_read  (m20k_read),
    .ll_read    (ll_read),
    .mlab_rdata (mlab_rdata),
    .m20k_rdata (m20k_rdata),
    .ll_rdata   (ll_rdata)
);

`default_nettype wire

//--- sim/ram_set_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ram_set_tb;

    import ram_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int MAX_ROWS     = 128;
    localparam int DEPTH        = 1 << ADDR_W;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef struct packed {
        ram_write_t write;
        addr_t      mlab_raddr;
        m20k_read_t m20k_read;
        ll_read_t   ll_read;
    } stim_row_t;

    // Expected output word and the edge it is due after
    typedef struct packed {
        int        due;
        logic      care;
        ram_data_t value;
    } expect_t;

    logic        clk;
    logic        arst_n;
    ram_write_t  write;
    addr_t       mlab_raddr;
    m20k_read_t  m20k_read;
    ll_read_t    ll_read;
    ram_data_t   mlab_rdata;
    ram_data_t   m20k_rdata;
    ram_data_t   ll_rdata;

    stim_row_t   rows [MAX_ROWS];
    stim_row_t   idle_row;
    int          n_rows;
    int          timeout_limit;
    int          cycle_count;

    ram_data_t   ref_mem   [DEPTH];
    logic        ref_known [DEPTH];
    ram_write_t  pend_write;
    expect_t     mlab_q [$];
    expect_t     m20k_q [$];
    ram_data_t   ll_exp;
    logic        ll_care;
    addr_t       ll_addr;

    ram_set_top ram_set_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .write      (write),
        .mlab_raddr (mlab_raddr),
        .m20k_read  (m20k_read),
        .ll_read    (ll_read),
        .mlab_rdata (mlab_rdata),
        .m20k_rdata (m20k_rdata),
        .ll_rdata   (ll_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= timeout_limit) begin
                $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
                $display("Test failures found");
                $fatal(1, "run timed out");
            end
        end
    end

    function automatic ram_write_t make_write(input logic en, input int addr,
                                              input ram_data_t data);
        ram_write_t w;
        w.en   = en;
        w.addr = addr_t'(addr);
        w.data = data;
        return w;
    endfunction

    function automatic m20k_read_t make_m20k(input logic en, input int addr);
        m20k_read_t r;
        r.en   = en;
        r.addr = addr_t'(addr);
        return r;
    endfunction

    function automatic ll_read_t make_ll(input logic ce, input logic clear, input int addr);
        ll_read_t r;
        r.ce    = ce;
        r.clear = clear;
        r.addr  = addr_t'(addr);
        return r;
    endfunction

    task automatic add_row(input ram_write_t w, input int ma, input m20k_read_t mr,
                           input ll_read_t lr);
        rows[n_rows].write      = w;
        rows[n_rows].mlab_raddr = addr_t'(ma);
        rows[n_rows].m20k_read  = mr;
        rows[n_rows].ll_read    = lr;
        n_rows++;
    endtask

    task automatic build_table();
        ram_write_t no_write;
        ram_data_t  new_word;
        no_write = make_write(1'b0, 0, '0);
        // Fill every address while reads trail the writes by two rows
        for (int a = 0; a < DEPTH; a++) begin
            add_row(make_write(1'b1, a, ram_data_t'($urandom())), a - 2,
                    make_m20k(1'b0, a - 2), make_ll(1'b0, 1'b0, 0));
        end
        for (int a = 0; a < DEPTH; a++) begin
            add_row(no_write, a, make_m20k(1'b1, a), make_ll(1'b1, 1'b0, a));
        end
        // M20K disabled read then enabled read
        add_row(no_write, 4, make_m20k(1'b0, 5), make_ll(1'b1, 1'b0, 6));
        add_row(no_write, 5, make_m20k(1'b1, 5), make_ll(1'b0, 1'b0, 0));
        // Low-latency stall in the middle of a read
        add_row(no_write, 7, make_m20k(1'b1, 7), make_ll(1'b1, 1'b0, 7));
        for (int i = 0; i < 4; i++) begin
            add_row(no_write, 8, make_m20k(1'b0, 8), make_ll(1'b0, 1'b0, 9));
        end
        add_row(no_write, 9, make_m20k(1'b1, 9), make_ll(1'b1, 1'b0, 9));
        // Clear on the data edge and reread the same address
        add_row(no_write, 10, make_m20k(1'b1, 10), make_ll(1'b1, 1'b1, 9));
        add_row(no_write, 11, make_m20k(1'b1, 11), make_ll(1'b1, 1'b0, 12));
        add_row(no_write, 12, make_m20k(1'b1, 12), make_ll(1'b0, 1'b0, 0));
        // New word differs from the first one written to address 3
        new_word = rows[3].write.data ^ (ram_data_t'($urandom()) | ram_data_t'(1));
        add_row(make_write(1'b1, 3, new_word), 13, make_m20k(1'b1, 13), make_ll(1'b1, 1'b0, 14));
        add_row(no_write, 14, make_m20k(1'b1, 14), make_ll(1'b1, 1'b0, 15));
        add_row(no_write, 3, make_m20k(1'b1, 3), make_ll(1'b1, 1'b0, 3));
        add_row(no_write, 3, make_m20k(1'b1, 3), make_ll(1'b1, 1'b0, 16));
        add_row(no_write, 16, make_m20k(1'b0, 16), make_ll(1'b1, 1'b0, 16));
    endtask

    task automatic apply_row(input stim_row_t row);
        write      = row.write;
        mlab_raddr = row.mlab_raddr;
        m20k_read  = row.m20k_read;
        ll_read    = row.ll_read;
    endtask

    // Expected outputs for the row sampled at this edge
    task automatic model_edge(input int edge_no, input stim_row_t row);
        expect_t item;
        if (row.ll_read.ce) begin
            if (row.ll_read.clear) begin
                ll_exp  = '0;
                ll_care = 1'b1;
            end else begin
                ll_exp  = ref_mem[ll_addr];
                ll_care = ref_known[ll_addr];
            end
            ll_addr = row.ll_read.addr;
        end
        // Write taken one edge ago lands in the array now
        if (pend_write.en) begin
            ref_mem[pend_write.addr]   = pend_write.data;
            ref_known[pend_write.addr] = 1'b1;
        end
        pend_write = row.write;
        item.due   = edge_no + 1;
        item.care  = ref_known[row.mlab_raddr];
        item.value = ref_mem[row.mlab_raddr];
        mlab_q.push_back(item);
        item.due = edge_no + 2;
        if (row.m20k_read.en) begin
            item.care  = ref_known[row.m20k_read.addr];
            item.value = ref_mem[row.m20k_read.addr];
        end else begin
            item.care  = 1'b1;
            item.value = '0;
        end
        m20k_q.push_back(item);
    endtask

    task automatic report_mismatch(input string name, input ram_data_t expected,
                                   input ram_data_t actual);
        $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Test failures found");
        $fatal(1, "output mismatch");
    endtask

    task automatic compare_mlab(input ram_data_t expected, input ram_data_t actual);
        if (actual !== expected) begin
            report_mismatch("mlab_rdata", expected, actual);
        end
    endtask

    task automatic compare_m20k(input ram_data_t expected, input ram_data_t actual);
        if (actual !== expected) begin
            report_mismatch("m20k_rdata", expected, actual);
        end
    endtask

    task automatic compare_ll(input ram_data_t expected, input ram_data_t actual);
        if (actual !== expected) begin
            report_mismatch("ll_rdata", expected, actual);
        end
    endtask

    task automatic check_outputs(input int edge_no);
        expect_t item;
        if (mlab_q.size() > 0 && mlab_q[0].due == edge_no) begin
            item = mlab_q.pop_front();
            if (item.care) begin
                compare_mlab(item.value, mlab_rdata);
            end
        end
        if (m20k_q.size() > 0 && m20k_q[0].due == edge_no) begin
            item = m20k_q.pop_front();
            if (item.care) begin
                compare_m20k(item.value, m20k_rdata);
            end
        end
        if (ll_care) begin
            compare_ll(ll_exp, ll_rdata);
        end
    endtask

    initial begin
        void'($urandom(92));
        arst_n     = 1'b1;
        write      = '0;
        mlab_raddr = '0;
        m20k_read  = '0;
        ll_read    = '0;
        idle_row   = '0;
        pend_write = '0;
        ll_exp     = '0;
        ll_care    = 1'b1;
        ll_addr    = '0;
        n_rows      = 0;
        cycle_count = 0;
        for (int a = 0; a < DEPTH; a++) begin
            ref_known[a] = 1'b0;
        end
        build_table();
        timeout_limit = n_rows + 50;

        #1 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        compare_mlab('0, mlab_rdata);
        compare_m20k('0, m20k_rdata);
        compare_ll('0, ll_rdata);
        apply_row(rows[0]);

        // Extra edges drain the M20K pipeline
        for (int e = 1; e <= n_rows + 2; e++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            model_edge(e, (e <= n_rows) ? rows[e-1] : idle_row);
            check_outputs(e);
            apply_row((e < n_rows) ? rows[e] : idle_row);
        end

        if (ram_set_top_i.ram_set_assertions_i.error_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Assertion failures: %0d", ram_set_top_i.ram_set_assertions_i.error_count);
            $display("Test failures found");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

//--- src/low_latency_ram.sv
`timescale 1ns/100ps
`default_nettype none

module low_latency_ram #(
    parameter int WIDTH      = 16,
    parameter int DEPTH_LOG2 = 5
) (
    input  logic                clk,
    input  logic                arst_n,
    input  ram_pkg::ram_write_t write,
    input  ram_pkg::ll_read_t   read,
    output ram_pkg::ram_data_t  rdata
);

    import ram_pkg::*;

    logic [DEPTH_LOG2-1:0] raddr_q;
    ram_data_t             array_rdata;
    ram_data_t             rdata_q;

    ram_array #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) ram_array_i (
        .clk    (clk),
        .arst_n (arst_n),
        .write  (write),
        .raddr  (raddr_q),
        .rdata  (array_rdata)
    );

    // Address stage, stalls with ce
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raddr_q <= '0;
        end else if (read.ce) begin
            raddr_q <= read.addr;
        end
    end

    // Output stage, clear only takes effect on an enabled edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else if (read.ce) begin
            if (read.clear) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= array_rdata;
            end
        end
    end

    assign rdata = rdata_q;

endmodule

`default_nettype wire

//--- src/m20k_ram.sv
`timescale 1ns/100ps
`default_nettype none

module m20k_ram #(
    parameter int WIDTH      = 16,
    parameter int DEPTH_LOG2 = 5
) (
    input  logic                clk,
    input  logic                arst_n,
    input  ram_pkg::ram_write_t write,
    input  ram_pkg::m20k_read_t read,
    output ram_pkg::ram_data_t  rdata
);

    import ram_pkg::*;

    logic                  read_en_q;
    logic [DEPTH_LOG2-1:0] raddr_q;
    ram_data_t             array_rdata;
    ram_data_t             masked_rdata;
    ram_data_t             stage1_q;
    ram_data_t             stage2_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_en_q <= 1'b0;
            raddr_q   <= '0;
        end else begin
            read_en_q <= read.en;
            raddr_q   <= read.addr;
        end
    end

    ram_array #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) ram_array_i (
        .clk    (clk),
        .arst_n (arst_n),
        .write  (write),
        .raddr  (raddr_q),
        .rdata  (array_rdata)
    );

    // Force to zero when the read was not enabled
    assign masked_rdata = read_en_q ? array_rdata : '0;

    // Two output stages, as in the hard block
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage1_q <= '0;
            stage2_q <= '0;
        end else begin
            stage1_q <= masked_rdata;
            stage2_q <= stage1_q;
        end
    end

    assign rdata = stage2_q;

endmodule

`default_nettype wire

//--- src/mlab_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mlab_ram #(
    parameter int WIDTH           = 16,
    parameter int DEPTH_LOG2      = 5,
    parameter int OUTPUT_REGISTER = 0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ram_pkg::ram_write_t   write,
    input  logic [DEPTH_LOG2-1:0] raddr,
    output ram_pkg::ram_data_t    rdata
);

    import ram_pkg::*;

    logic [DEPTH_LOG2-1:0] raddr_q;
    ram_data_t             array_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raddr_q <= '0;
        end else begin
            raddr_q <= raddr;
        end
    end

    ram_array #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) ram_array_i (
        .clk    (clk),
        .arst_n (arst_n),
        .write  (write),
        .raddr  (raddr_q),
        .rdata  (array_rdata)
    );

    if (OUTPUT_REGISTER != 0) begin : g_out_reg
        ram_data_t rdata_q;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= array_rdata;
            end
        end

        assign rdata = rdata_q;
    end else begin : g_out_comb
        // Data follows the registered address directly
        assign rdata = array_rdata;
    end

endmodule

`default_nettype wire

//--- src/ram_array.sv
`timescale 1ns/100ps
`default_nettype none

module ram_array #(
    parameter int WIDTH      = 16,
    parameter int DEPTH_LOG2 = 5
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  ram_pkg::ram_write_t     write,
    input  logic [DEPTH_LOG2-1:0]   raddr,
    output ram_pkg::ram_data_t      rdata
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];

    logic                  write_en_q;
    logic [DEPTH_LOG2-1:0] write_addr_q;
    logic [WIDTH-1:0]      write_data_q;

    // Write strobe is the only control state here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_en_q <= 1'b0;
        end else begin
            write_en_q <= write.en;
        end
    end

    always_ff @(posedge clk) begin
        write_addr_q <= write.addr;
        write_data_q <= write.data;
    end

    // Array is written one cycle after the request
    always_ff @(posedge clk) begin
        if (write_en_q) begin
            mem[write_addr_q] <= write_data_q;
        end
    end

    // Unregistered read, the callers supply the pipeline
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

//--- src/ram_pkg.sv
`default_nettype none

package ram_pkg;

    // Default word and address widths
    localparam int DATA_W = 16;
    localparam int ADDR_W = 5;

    typedef logic [DATA_W-1:0] ram_data_t;

    // Shared write port, broadcast to every memory
    typedef struct packed {
        logic             en;
        logic [ADDR_W-1:0] addr;
        ram_data_t        data;
    } ram_write_t;

    // Block RAM read request
    typedef struct packed {
        logic             en;
        logic [ADDR_W-1:0] addr;
    } m20k_read_t;

    // Low-latency read request
    typedef struct packed {
        logic             ce;
        logic             clear;
        logic [ADDR_W-1:0] addr;
    } ll_read_t;

endpackage

`default_nettype wire

//--- src/ram_set_top.sv
`timescale 1ns/100ps
`default_nettype none

module ram_set_top #(
    parameter int WIDTH           = ram_pkg::DATA_W,
    parameter int DEPTH_LOG2      = ram_pkg::ADDR_W,
    parameter int OUTPUT_REGISTER = 1
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ram_pkg::ram_write_t   write,
    input  logic [DEPTH_LOG2-1:0] mlab_raddr,
    input  ram_pkg::m20k_read_t   m20k_read,
    input  ram_pkg::ll_read_t     ll_read,
    output ram_pkg::ram_data_t    mlab_rdata,
    output ram_pkg::ram_data_t    m20k_rdata,
    output ram_pkg::ram_data_t    ll_rdata
);

    import ram_pkg::*;

    // Port structs are sized by the package, so the parameters must agree
    if (WIDTH != DATA_W || DEPTH_LOG2 != ADDR_W) begin : g_width_check
        $fatal(1, "ram_set_top: WIDTH/DEPTH_LOG2 do not match ram_pkg DATA_W/ADDR_W");
    end

    // Same write goes to all three arrays
    mlab_ram #(
        .WIDTH           (WIDTH),
        .DEPTH_LOG2      (DEPTH_LOG2),
        .OUTPUT_REGISTER (OUTPUT_REGISTER)
    ) mlab_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .write  (write),
        .raddr  (mlab_raddr),
        .rdata  (mlab_rdata)
    );

    m20k_ram #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) m20k_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .write  (write),
        .read   (m20k_read),
        .rdata  (m20k_rdata)
    );

    low_latency_ram #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) low_latency_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .write  (write),
        .read   (ll_read),
        .rdata  (ll_rdata)
    );

endmodule

`default_nettype wire
